// File: tb/sd_link_tests.txt
# cmd(dec) arg(hex) crc_ok kind(dec) state(dec) payload[127:96](hex) flags(hex)
# kind 0 none 1 bad 2 r1 3 r1b 4 r2 5 r3 6 r6 7 r7 / flags {mode_4bit desel crc_err unhandled}
0  00000000 1 0 0 00000000 0
8  000001aa 1 7 0 000001aa 0
55 00000000 1 2 0 00000120 0
41 40ff8000 1 5 0 40ff8000 0
55 00000000 1 2 0 00000120 0
41 40ff8000 1 5 0 40ff8000 0
55 00000000 1 2 0 00000120 0
41 40ff8000 1 5 0 40ff8000 0
55 00000000 1 2 0 00000120 0
41 40ff8000 1 5 1 c0ff8000 0
2  00000000 1 4 2 03534453 0
3  00000000 1 6 3 13370500 0
7  13370000 1 3 4 00000700 0
13 13370000 1 2 4 00000900 0
55 13370000 1 2 4 00000920 0
6  00000002 1 2 4 00000900 8
2  00000000 1 1 4 00000000 8
13 13370000 1 2 4 00400900 8
13 13370000 1 2 4 00000900 8
13 13370000 0 0 4 00000000 a
13 13370000 1 2 4 00800900 a
7  00010000 1 0 3 00000000 e
9  13370000 1 4 3 400e0032 e
16 00000000 1 1 3 00000000 f
13 13370000 1 2 3 00400700 f
55 13370000 1 2 3 00000720 f
13 13370000 1 2 3 00000700 f
0  00000000 1 0 0 00000000 2

// File: tb.f
+incdir+source
source/sd_link_pkg.sv
source/sd_link_synch.sv
source/sd_cmd_decoder.sv
source/sd_card_status.sv
source/sd_resp_builder.sv
source/sd_link_top.sv
tb/tb_sd_link.sv

// File: run_sim.sh
#!/bin/sh
# builds the SD link testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns -f tb.f --top-module tb_sd_link \
   -o tb_sd_link_sim

output=$(./obj_dir/tb_sd_link_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
   exit 0
else
   exit 1
fi

// File: tb/tb_sd_link.sv
// testbench for the SD link command side
// file-driven commands, PHY response model and checks
`timescale 1ns/1ns
`default_nettype none

module tb_sd_link;

   logic         clk_50 = 1'b0;
   logic         reset_s;
   logic [47:0]  phy_cmd_in;
   logic         phy_cmd_crc_good;
   logic         phy_cmd_act;
   logic         phy_resp_done;
   logic [135:0] phy_resp_out;
   logic [3:0]   phy_resp_type;
   logic         phy_resp_act;
   logic         phy_mode_4bit;
   logic [3:0]   link_card_state;
   logic [5:0]   cmd_in_last;
   logic         err_cmd_crc;
   logic         err_unhandled_cmd;
   logic         err_host_is_spi;
   logic         info_card_desel;

   int           seed;
   int           error_count;
   int           pass_count;
   int           test_count;
   logic         aborted;

   sd_link_top sd_link_top_i (
      .clk_50            (clk_50),
      .reset_s           (reset_s),
      .phy_cmd_in        (phy_cmd_in),
      .phy_cmd_crc_good  (phy_cmd_crc_good),
      .phy_cmd_act       (phy_cmd_act),
      .phy_resp_done     (phy_resp_done),
      .phy_resp_out      (phy_resp_out),
      .phy_resp_type     (phy_resp_type),
      .phy_resp_act      (phy_resp_act),
      .phy_mode_4bit     (phy_mode_4bit),
      .link_card_state   (link_card_state),
      .cmd_in_last       (cmd_in_last),
      .err_cmd_crc       (err_cmd_crc),
      .err_unhandled_cmd (err_unhandled_cmd),
      .err_host_is_spi   (err_host_is_spi),
      .info_card_desel   (info_card_desel)
   );

   always #2 clk_50 = ~clk_50;

   task automatic check_value(input int num, input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Mismatch test %0d %s: got %h expected %h", num, name, got, exp);
         error_count++;
      end
   endtask

   // frame with start and direction bits, CRC field left to the PHY
   task automatic send_command(input logic [5:0] idx, input logic [31:0] arg,
                               input logic crc_ok);
      @(posedge clk_50);
      #1;
      phy_cmd_in       = {2'b01, idx, arg, 7'h00, 1'b1};
      phy_cmd_crc_good = crc_ok;
      @(posedge clk_50);
      #1;
      phy_cmd_act = 1'b1;
      @(posedge clk_50);
      @(posedge clk_50);
      #1;
      phy_cmd_act = 1'b0;
   endtask

   task automatic wait_resp_act(output logic seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < 200) begin
         @(negedge clk_50);
         seen = phy_resp_act;
         cycles++;
      end
   endtask

   // response latency is a few cycles, so a quiet window means no response
   task automatic watch_quiet(output logic seen);
      int cycles;
      seen = 1'b0;
      for (cycles = 0; cycles < 16 && !seen; cycles++) begin
         @(negedge clk_50);
         seen = phy_resp_act;
      end
   endtask

   // PHY side: done after a random hold-off, dropped once act falls
   task automatic answer_response(output logic ok);
      int delay;
      int cycles;
      delay = ($random(seed) & 32'h7) + 1;
      repeat (delay) @(posedge clk_50);
      #1;
      phy_resp_done = 1'b1;
      ok     = 1'b0;
      cycles = 0;
      while (!ok && cycles < 200) begin
         @(negedge clk_50);
         ok = !phy_resp_act;
         cycles++;
      end
      @(posedge clk_50);
      #1;
      phy_resp_done = 1'b0;
   endtask

   task automatic run_test(input int num, input logic [5:0] idx, input logic [31:0] arg,
                           input logic crc_ok, input logic [3:0] exp_kind,
                           input logic [3:0] exp_state, input logic [31:0] exp_payload,
                           input logic [3:0] exp_flags);
      int         errors_before;
      logic       seen;
      logic       ok;
      logic [7:0] exp_head;
      errors_before = error_count;
      send_command(idx, arg, crc_ok);
      if (!crc_ok || exp_kind < 4'd2) begin
         watch_quiet(seen);
         assert (!seen) else begin
            $display("test %0d: response sent where none was expected", num);
            error_count++;
         end
         if (seen) begin
            answer_response(ok);
            aborted = !ok;
         end
      end else begin
         wait_resp_act(seen);
         assert (seen) else begin
            $display("test %0d: timeout waiting for phy_resp_act", num);
            error_count++;
            aborted = 1'b1;
         end
         if (seen) begin
            // r2 and r3 carry all ones in the index field
            exp_head = (exp_kind inside {4'd4, 4'd5}) ? 8'h3f : {2'b00, idx};
            check_value(num, "phy_resp_out[135:128]", 32'(phy_resp_out[135:128]),
                        32'(exp_head));
            check_value(num, "phy_resp_out[127:96]", phy_resp_out[127:96], exp_payload);
            answer_response(ok);
            assert (ok) else begin
               $display("test %0d: phy_resp_act stayed high after phy_resp_done", num);
               error_count++;
               aborted = 1'b1;
            end
         end
      end
      if (crc_ok) begin
         check_value(num, "phy_resp_type", 32'(phy_resp_type), 32'(exp_kind));
         check_value(num, "cmd_in_last", 32'(cmd_in_last), 32'(idx));
      end
      check_value(num, "link_card_state", 32'(link_card_state), 32'(exp_state));
      check_value(num, "phy_mode_4bit", 32'(phy_mode_4bit), 32'(exp_flags[3]));
      check_value(num, "info_card_desel", 32'(info_card_desel), 32'(exp_flags[2]));
      check_value(num, "err_cmd_crc", 32'(err_cmd_crc), 32'(exp_flags[1]));
      check_value(num, "err_unhandled_cmd", 32'(err_unhandled_cmd), 32'(exp_flags[0]));
      check_value(num, "err_host_is_spi", 32'(err_host_is_spi), 32'h0);
      if (error_count == errors_before) begin
         pass_count++;
         $display("test %0d cmd%0d: ok", num, idx);
      end else begin
         $display("test %0d cmd%0d: %0d errors", num, idx, error_count - errors_before);
      end
   endtask

   initial begin
      int          fd;
      int          got;
      int          fields;
      string       line;
      logic [31:0] f_idx;
      logic [31:0] f_arg;
      logic [31:0] f_crc;
      logic [31:0] f_kind;
      logic [31:0] f_state;
      logic [31:0] f_payload;
      logic [31:0] f_flags;
      seed             = 32'hc1cfcd01;
      error_count      = 0;
      pass_count       = 0;
      test_count       = 0;
      aborted          = 1'b0;
      reset_s          = 1'b0;
      phy_cmd_in       = '0;
      phy_cmd_crc_good = 1'b0;
      phy_cmd_act      = 1'b0;
      phy_resp_done    = 1'b0;
      repeat (4) @(posedge clk_50);
      #1;
      reset_s = 1'b1;
      fd = $fopen("tb/sd_link_tests.txt", "r");
      if (fd == 0) begin
         $display("cannot open tb/sd_link_tests.txt");
         aborted = 1'b1;
      end else begin
         while (!aborted && $feof(fd) == 0) begin
            line   = "";
            got    = $fgets(line, fd);
            fields = $sscanf(line, "%d %h %d %d %d %h %h", f_idx, f_arg, f_crc, f_kind,
                             f_state, f_payload, f_flags);
            // comment and blank lines scan no fields
            if (got > 0 && fields == 7) begin
               test_count++;
               run_test(test_count, f_idx[5:0], f_arg, f_crc[0], f_kind[3:0],
                        f_state[3:0], f_payload, f_flags[3:0]);
            end
         end
         $fclose(fd);
      end
      $display("%0d tests run, %0d ok, %0d errors", test_count, pass_count, error_count);
      if (error_count == 0 && !aborted && test_count > 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/sd_link_top.sv
// SD link command side: sequencer FSM, PHY response handshake
// input synchronizers, decoder, status register and response builder
`timescale 1ns/1ns
`default_nettype none

module sd_link_top (
   input  wire                          clk_50,
   input  wire                          reset_s,
   input  wire sd_link_pkg::cmd_frame_t phy_cmd_in,
   input  wire                          phy_cmd_crc_good,
   input  wire                          phy_cmd_act,
   input  wire                          phy_resp_done,
   output sd_link_pkg::resp_frame_t     phy_resp_out,
   output sd_link_pkg::resp_kind_e      phy_resp_type,
   output logic                         phy_resp_act,
   output logic                         phy_mode_4bit,
   output sd_link_pkg::card_state_e     link_card_state,
   output sd_link_pkg::cmd_index_t      cmd_in_last,
   output logic                         err_cmd_crc,
   output logic                         err_unhandled_cmd,
   output logic                         err_host_is_spi,
   output logic                         info_card_desel
);
   import sd_link_pkg::*;

   seq_state_e   seq;
   card_state_e  card_state;
   card_state_e  card_state_next;
   cmd_frame_t   cmd_s;
   cmd_frame_t   cmd_latch;
   cmd_index_t   cmd_index;
   cmd_arg_t     cmd_arg;
   logic         crc_good_s;
   logic         act_rise;
   logic         done_rise;
   logic         decode_second;
   logic         decode_go;
   logic         retry_wait;
   logic         resp_finish;
   resp_kind_e   resp_kind;
   rca_t         card_rca;
   ocr_t         card_ocr;
   logic [7:0]   r7_echo;
   logic         app_cmd;
   logic         status_set_illegal;
   logic         crc_bad;
   logic         cmd_accepted;
   logic         set_illegal;
   logic         clear_on_read;
   card_status_t card_status;
   resp_frame_t  resp_frame;

   sd_link_synch #(.width(48)) cmd_synch_i (
      .clk_50 (clk_50), .d(phy_cmd_in), .q(cmd_s), .rise());
   sd_link_synch crc_synch_i (
      .clk_50 (clk_50), .d(phy_cmd_crc_good), .q(crc_good_s), .rise());
   sd_link_synch act_synch_i (
      .clk_50 (clk_50), .d(phy_cmd_act), .q(), .rise(act_rise));
   sd_link_synch done_synch_i (
      .clk_50 (clk_50), .d(phy_resp_done), .q(), .rise(done_rise));

   assign cmd_index       = cmd_latch[45:40];
   assign cmd_arg         = cmd_latch[39:8];
   assign link_card_state = card_state;

   // event pulses derived from the sequencer
   assign crc_bad       = (seq == seq_idle) && act_rise && !crc_good_s;
   assign decode_go     = (seq == seq_decode) && !decode_second;
   assign retry_wait    = decode_go && app_cmd && !is_acmd(cmd_index);
   assign set_illegal   = (seq == seq_status) && status_set_illegal;
   assign resp_finish   = (seq == seq_send) && done_rise;
   assign cmd_accepted  = resp_finish || ((seq == seq_format) && (resp_kind == resp_none));
   assign clear_on_read = resp_finish && (cmd_index == cmd13_send_status);

   sd_cmd_decoder decoder_i (
      .clk_50             (clk_50),
      .reset_s            (reset_s),
      .decode_go          (decode_go),
      .cmd_index          (cmd_index),
      .cmd_arg            (cmd_arg),
      .card_state         (card_state),
      .resp_kind          (resp_kind),
      .card_state_next    (card_state_next),
      .card_rca           (card_rca),
      .card_ocr           (card_ocr),
      .r7_echo            (r7_echo),
      .mode_4bit          (phy_mode_4bit),
      .app_cmd            (app_cmd),
      .status_set_illegal (status_set_illegal),
      .err_unhandled_cmd  (err_unhandled_cmd),
      .err_host_is_spi    (err_host_is_spi),
      .info_card_desel    (info_card_desel)
   );

   sd_card_status status_i (
      .clk_50        (clk_50),
      .reset_s       (reset_s),
      .crc_bad       (crc_bad),
      .cmd_accepted  (cmd_accepted),
      .set_illegal   (set_illegal),
      .app_cmd       (app_cmd),
      .clear_on_read (clear_on_read),
      .card_state    (card_state),
      .card_status   (card_status)
   );

   sd_resp_builder resp_builder_i (
      .resp_kind   (resp_kind),
      .cmd_index   (cmd_index),
      .card_status (card_status),
      .card_rca    (card_rca),
      .card_ocr    (card_ocr),
      .r7_echo     (r7_echo),
      .resp_frame  (resp_frame)
   );

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         seq           <= seq_reset;
         card_state    <= card_idle;
         phy_resp_act  <= 1'b0;
         phy_resp_type <= resp_none;
         err_cmd_crc   <= 1'b0;
         cmd_in_last   <= '0;
         decode_second <= 1'b0;
      end else begin
         case (seq)
            seq_reset: seq <= seq_idle;
            seq_idle: begin
               // edges arriving while a response is out are ignored
               if (act_rise && crc_good_s) begin
                  cmd_in_last <= cmd_s[45:40];
                  seq         <= seq_decode;
               end else if (act_rise) begin
                  err_cmd_crc <= 1'b1;
               end
            end
            seq_decode: begin
               // one extra cycle when an ACMD falls back to CMD
               if (retry_wait) begin
                  decode_second <= 1'b1;
               end else begin
                  decode_second <= 1'b0;
                  seq           <= seq_status;
               end
            end
            seq_status: seq <= seq_format;
            seq_format: begin
               phy_resp_type <= resp_kind;
               if (resp_kind == resp_none) begin
                  card_state <= card_state_next;
                  seq        <= seq_idle;
               end else if (resp_kind == resp_bad) begin
                  seq <= seq_idle;
               end else begin
                  phy_resp_act <= 1'b1;
                  seq          <= seq_send;
               end
            end
            seq_send: begin
               // PHY holds done off as long as it needs
               if (done_rise) begin
                  phy_resp_act <= 1'b0;
                  card_state   <= card_state_next;
                  seq          <= seq_idle;
               end
            end
            default: seq <= seq_idle;
         endcase
      end
   end

   // command and response payload
   always_ff @(posedge clk_50) begin
      if (seq == seq_idle && act_rise && crc_good_s) begin
         cmd_latch <= cmd_s;
      end
      if (seq == seq_format) begin
         phy_resp_out <= resp_frame;
      end
   end

endmodule

`default_nettype wire

// File: source/sd_resp_builder.sv
// response frame formatter for R1, R1b, R2, R3, R6 and R7
`timescale 1ns/1ns
`default_nettype none
`include "sd_link_settings.svh"

module sd_resp_builder (
   input  wire sd_link_pkg::resp_kind_e   resp_kind,
   input  wire sd_link_pkg::cmd_index_t   cmd_index,
   input  wire sd_link_pkg::card_status_t card_status,
   input  wire sd_link_pkg::rca_t         card_rca,
   input  wire sd_link_pkg::ocr_t         card_ocr,
   input  wire [7:0]                      r7_echo,
   output sd_link_pkg::resp_frame_t       resp_frame
);
   import sd_link_pkg::*;

   localparam logic [127:0] cid = `SD_CID_VALUE;
   localparam logic [127:0] csd = `SD_CSD_VALUE;

   logic [15:0] status_short;

   // R6 keeps bits 23, 22, 19 and 12:0
   assign status_short = {card_status[stat_com_crc_error], card_status[stat_illegal_command],
                          card_status[19], card_status[12:0]};

   always_comb begin
      case (resp_kind)
         resp_r1, resp_r1b: begin
            resp_frame = {2'b00, cmd_index, card_status, 8'h01, 88'h0};
         end
         resp_r2: begin
            // CRC inside the register image, end bit forced
            if (cmd_index == cmd9_send_csd) begin
               resp_frame = {2'b00, 6'b111111, csd[127:1], 1'b1};
            end else begin
               resp_frame = {2'b00, 6'b111111, cid[127:1], 1'b1};
            end
         end
         resp_r3: begin
            // no CRC in R3, all ones
            resp_frame = {2'b00, 6'b111111, card_ocr, 8'hff, 88'h0};
         end
         resp_r6: begin
            resp_frame = {2'b00, cmd_index, card_rca, status_short, 8'h01, 88'h0};
         end
         resp_r7: begin
            resp_frame = {2'b00, cmd_index, 20'h0, 4'b0001, r7_echo, 8'h01, 88'h0};
         end
         default: begin
            resp_frame = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: source/sd_card_status.sv
// 32-bit card status register
// error bits, clear-on-read, state and app command mirror
`timescale 1ns/1ns
`default_nettype none

module sd_card_status (
   input  wire                           clk_50,
   input  wire                           reset_s,
   input  wire                           crc_bad,
   input  wire                           cmd_accepted,
   input  wire                           set_illegal,
   input  wire                           app_cmd,
   input  wire                           clear_on_read,
   input  wire sd_link_pkg::card_state_e card_state,
   output sd_link_pkg::card_status_t     card_status
);
   import sd_link_pkg::*;

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         card_status <= '0;
      end else begin
         if (cmd_accepted) begin
            // reported once, in the response after the failure
            card_status[stat_com_crc_error]   <= 1'b0;
            card_status[stat_illegal_command] <= 1'b0;
         end
         if (crc_bad) begin
            card_status[stat_com_crc_error] <= 1'b1;
         end
         if (set_illegal) begin
            card_status[stat_illegal_command] <= 1'b1;
         end
         if (clear_on_read) begin
            card_status[stat_out_of_range] <= 1'b0;
         end
         // current_state field
         card_status[12:9]                <= card_state;
         card_status[stat_ready_for_data] <= 1'b1;
         card_status[stat_app_cmd]        <= app_cmd;
      end
   end

endmodule

`default_nettype wire

// File: source/sd_cmd_decoder.sv
// command decoder with RCA, OCR and application command state
// per-command state rules, response kind and error flags
`timescale 1ns/1ns
`default_nettype none
`include "sd_link_settings.svh"

module sd_cmd_decoder (
   input  wire                           clk_50,
   input  wire                           reset_s,
   input  wire                           decode_go,
   input  wire sd_link_pkg::cmd_index_t  cmd_index,
   input  wire sd_link_pkg::cmd_arg_t    cmd_arg,
   input  wire sd_link_pkg::card_state_e card_state,
   output sd_link_pkg::resp_kind_e       resp_kind,
   output sd_link_pkg::card_state_e      card_state_next,
   output sd_link_pkg::rca_t             card_rca,
   output sd_link_pkg::ocr_t             card_ocr,
   output logic [7:0]                    r7_echo,
   output logic                          mode_4bit,
   output logic                          app_cmd,
   output logic                          status_set_illegal,
   output logic                          err_unhandled_cmd,
   output logic                          err_host_is_spi,
   output logic                          info_card_desel
);
   import sd_link_pkg::*;

   // capacity status set but not yet powered up
   localparam ocr_t ocr_init = {2'b01, 6'h00, `SD_OCR_VOLTAGE_WINDOW};

   logic [3:0]  acmd41_count;
   logic        retry;
   logic        decode_en;
   logic        rca_match;
   resp_kind_e  kind_d;
   card_state_e state_d;
   rca_t        rca_d;
   ocr_t        ocr_d;
   logic [3:0]  count_d;
   logic        mode_d;
   logic        app_d;
   logic        retry_d;
   logic        desel_d;
   logic        unhandled_d;
   logic        spi_d;

   assign decode_en = decode_go | retry;
   assign rca_match = (cmd_arg[31:16] == card_rca);

   always_comb begin
      kind_d      = resp_bad;
      state_d     = card_state;
      rca_d       = card_rca;
      ocr_d       = card_ocr;
      count_d     = acmd41_count;
      mode_d      = mode_4bit;
      app_d       = 1'b0;
      retry_d     = 1'b0;
      desel_d     = info_card_desel;
      unhandled_d = err_unhandled_cmd;
      spi_d       = err_host_is_spi;
      if (app_cmd && !is_acmd(cmd_index)) begin
         // unknown ACMD runs again next cycle as a plain CMD
         retry_d = 1'b1;
      end else if (app_cmd) begin
         if (cmd_index == acmd6_set_bus_width) begin
            if (card_state == card_tran) begin
               kind_d = resp_r1;
               mode_d = cmd_arg[1];
            end
         end else if (card_state == card_idle) begin
            kind_d  = resp_r3;
            count_d = acmd41_count + 4'd1;
            // zero window is an inquiry, and no HCS means never ready
            if (cmd_arg[23:0] != 24'h0 && cmd_arg[30] &&
                acmd41_count > 4'(`SD_ACMD41_READY_COUNT - 1)) begin
               ocr_d[`SD_OCR_BUSY_BIT] = 1'b1;
               state_d                 = card_ready;
            end
         end
      end else begin
         case (cmd_index)
            cmd0_go_idle: begin
               if (card_state != card_ina) begin
                  kind_d      = resp_none;
                  state_d     = card_idle;
                  rca_d       = '0;
                  ocr_d       = ocr_init;
                  count_d     = '0;
                  mode_d      = 1'b0;
                  desel_d     = 1'b0;
                  unhandled_d = 1'b0;
                  spi_d       = 1'b0;
               end
            end
            cmd2_all_send_cid: begin
               if (card_state == card_ready) begin
                  kind_d  = resp_r2;
                  state_d = card_ident;
               end
            end
            cmd3_send_rca: begin
               if (card_state inside {card_ident, card_stby}) begin
                  kind_d  = resp_r6;
                  rca_d   = card_rca + `SD_RCA_STEP;
                  state_d = card_stby;
               end
            end
            cmd7_select_card: begin
               if (!rca_match) begin
                  // another card addressed so drop off quietly
                  kind_d  = resp_none;
                  desel_d = 1'b1;
                  if (card_state inside {card_tran, card_data}) begin
                     state_d = card_stby;
                  end else if (card_state == card_prg) begin
                     state_d = card_dis;
                  end
               end else if (card_state inside {card_stby, card_dis}) begin
                  kind_d  = resp_r1b;
                  state_d = card_tran;
               end
            end
            cmd8_send_if_cond: begin
               if (card_state == card_idle) begin
                  kind_d = (cmd_arg[11:8] == 4'b0001) ? resp_r7 : resp_none;
               end
            end
            cmd9_send_csd, cmd10_send_cid: begin
               if (!rca_match) begin
                  kind_d = resp_none;
               end else if (card_state == card_stby) begin
                  kind_d = resp_r2;
               end
            end
            cmd13_send_status: begin
               if (!rca_match) begin
                  kind_d = resp_none;
               end else if (card_state inside {card_stby, card_tran, card_data,
                                               card_rcv, card_prg, card_dis}) begin
                  kind_d = resp_r1;
               end
            end
            cmd55_app_cmd: begin
               if (!rca_match) begin
                  kind_d = resp_none;
               end else if (!(card_state inside {card_ready, card_ident, card_ina})) begin
                  kind_d = resp_r1;
                  app_d  = 1'b1;
               end
            end
            default: begin
               // CMD1 comes from SPI hosts and CMD5 from SDIO probing
               if (!(cmd_index inside {cmd1_send_op_cond, cmd5_io_send_op_cond})) begin
                  unhandled_d = 1'b1;
               end
               if (cmd_index == cmd1_send_op_cond) begin
                  spi_d = 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         resp_kind          <= resp_none;
         card_state_next    <= card_idle;
         card_rca           <= '0;
         card_ocr           <= ocr_init;
         acmd41_count       <= '0;
         mode_4bit          <= 1'b0;
         app_cmd            <= 1'b0;
         retry              <= 1'b0;
         status_set_illegal <= 1'b0;
         err_unhandled_cmd  <= 1'b0;
         err_host_is_spi    <= 1'b0;
         info_card_desel    <= 1'b0;
      end else if (decode_en) begin
         resp_kind          <= kind_d;
         card_state_next    <= state_d;
         card_rca           <= rca_d;
         card_ocr           <= ocr_d;
         acmd41_count       <= count_d;
         mode_4bit          <= mode_d;
         app_cmd            <= app_d;
         retry              <= retry_d;
         status_set_illegal <= (kind_d == resp_bad) && !retry_d;
         err_unhandled_cmd  <= unhandled_d;
         err_host_is_spi    <= spi_d;
         info_card_desel    <= desel_d;
      end
   end

   // CMD8 check pattern
   always_ff @(posedge clk_50) begin
      if (decode_en) begin
         r7_echo <= cmd_arg[7:0];
      end
   end

endmodule

`default_nettype wire

// File: source/sd_link_synch.sv
// three-stage synchronizer with rising edge detect
`timescale 1ns/1ns
`default_nettype none

module sd_link_synch #(
   parameter int width = 1
) (
   input  wire              clk_50,
   input  wire [width-1:0]  d,
   output logic [width-1:0] q,
   output logic [width-1:0] rise
);

   logic [width-1:0] stage1;
   logic [width-1:0] stage2;
   logic [width-1:0] stage3;

   always_ff @(posedge clk_50) begin
      stage1 <= d;
      stage2 <= stage1;
      stage3 <= stage2;
      // lines up with the first high cycle of q
      rise   <= stage2 & ~stage3;
   end

   assign q = stage3;

endmodule

`default_nettype wire

// File: source/sd_link_pkg.sv
// shared types, command indices and card status bit positions
// plus the application command lookup
`default_nettype none

package sd_link_pkg;

   typedef logic [5:0]   cmd_index_t;
   typedef logic [31:0]  cmd_arg_t;
   typedef logic [47:0]  cmd_frame_t;
   typedef logic [15:0]  rca_t;
   typedef logic [31:0]  card_status_t;
   typedef logic [31:0]  ocr_t;
   // 48-bit responses sit left-aligned
   typedef logic [135:0] resp_frame_t;

   typedef enum logic [3:0] {
      card_idle = 4'd0, card_ready = 4'd1, card_ident = 4'd2, card_stby = 4'd3,
      card_tran = 4'd4, card_data = 4'd5, card_rcv = 4'd6, card_prg = 4'd7,
      card_dis = 4'd8, card_ina = 4'd15
   } card_state_e;

   typedef enum logic [3:0] {
      resp_none, resp_bad, resp_r1, resp_r1b, resp_r2, resp_r3, resp_r6, resp_r7
   } resp_kind_e;

   typedef enum logic [2:0] {
      seq_reset, seq_idle, seq_decode, seq_status, seq_format, seq_send
   } seq_state_e;

   localparam cmd_index_t cmd0_go_idle           = 6'd0;
   localparam cmd_index_t cmd1_send_op_cond      = 6'd1;
   localparam cmd_index_t cmd2_all_send_cid      = 6'd2;
   localparam cmd_index_t cmd3_send_rca          = 6'd3;
   localparam cmd_index_t cmd5_io_send_op_cond   = 6'd5;
   localparam cmd_index_t cmd7_select_card       = 6'd7;
   localparam cmd_index_t cmd8_send_if_cond      = 6'd8;
   localparam cmd_index_t cmd9_send_csd          = 6'd9;
   localparam cmd_index_t cmd10_send_cid         = 6'd10;
   localparam cmd_index_t cmd13_send_status      = 6'd13;
   localparam cmd_index_t cmd55_app_cmd          = 6'd55;
   localparam cmd_index_t acmd6_set_bus_width    = 6'd6;
   localparam cmd_index_t acmd41_sd_send_op_cond = 6'd41;

   localparam int stat_out_of_range    = 31;
   localparam int stat_com_crc_error   = 23;
   localparam int stat_illegal_command = 22;
   localparam int stat_ready_for_data  = 8;
   localparam int stat_app_cmd         = 5;

   // application commands this card knows
   function automatic logic is_acmd(input cmd_index_t idx);
      return (idx == acmd6_set_bus_width) || (idx == acmd41_sd_send_op_cond);
   endfunction

endpackage

`default_nettype wire

// File: source/sd_link_settings.svh
// card identity and power-up constants
// CID and CSD contents, OCR voltage window, RCA step, ACMD41 ready count
`ifndef SD_LINK_SETTINGS_SVH
`define SD_LINK_SETTINGS_SVH

// CID fields, MSB first
`define SD_CID_MID 8'h03
`define SD_CID_OID 16'h5344
// product name "SDLNK"
`define SD_CID_PNM 40'h53444c4e4b
`define SD_CID_PRV 8'h10
`define SD_CID_PSN 32'h00002a51
`define SD_CID_MDT 12'h0f1
`define SD_CID_VALUE {`SD_CID_MID, `SD_CID_OID, `SD_CID_PNM, `SD_CID_PRV, \
                      `SD_CID_PSN, 4'h0, `SD_CID_MDT, 8'h01}

// version 2.0 CSD, high capacity layout
`define SD_CSD_VALUE 128'h400e00325b5900003b377f800a400001

// 2.7 to 3.6 V
`define SD_OCR_VOLTAGE_WINDOW 24'hff8000
`define SD_OCR_BUSY_BIT 31

`define SD_RCA_STEP 16'h1337
`define SD_ACMD41_READY_COUNT 3

`endif
